/* source/mem_share_config.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Sizes for the shared memory design
// Included by the package and by any module that needs a size
// ~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_SHARE_CONFIG_SVH
`define MEM_SHARE_CONFIG_SVH

// Word address width, gives a 64-word memory
`define MS_ADDR_W 6

// Data word width
`define MS_DATA_W 16

// Buffered responses per adapter, at least the memory latency of 1
`define MS_BUF_DEPTH 2

// Requester ports on the shared memory
`define MS_NUM_PORTS 2

// Word returned as the response to a write
`define MS_WR_ACK 16'hA5A5

`endif

/* source/mem_share_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Payload types shared by the adapters, the arbiter and the memory
// Compile before any module that names these types
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_share_config.svh"

package mem_share_pkg;

  // Memory request payload
  // Write flag first, then word address and write data
  typedef struct packed {
    logic                  we;
    logic [`MS_ADDR_W-1:0] addr;
    logic [`MS_DATA_W-1:0] wdata;
  } mem_req_t;

  // Memory response payload
  // Read data, or the write acknowledge word
  typedef struct packed {
    logic [`MS_DATA_W-1:0] rdata;
  } mem_resp_t;

  // Index of a requester port
  // Tags the response that is in flight in the memory
  typedef logic [$clog2(`MS_NUM_PORTS)-1:0] port_id_t;

endpackage

`default_nettype wire

/* source/resp_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fall-through FIFO for memory responses
// An empty FIFO passes the input word straight to the output
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module resp_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mem_share_pkg::mem_resp_t  data_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output mem_share_pkg::mem_resp_t  data_o,
  output logic                      valid_o,
  input  logic                      ready_i
);
  import mem_share_pkg::*;

  // A single entry still needs one pointer bit
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  mem_resp_t       store_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            empty;
  logic            full;
  logic            push;
  logic            pop;

  // Circular increment of a pointer
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty   = (count_q == '0);
  assign full    = (count_q == CntW'(Depth));
  assign ready_o = ~full;

  // Fall-through output when nothing is stored
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : store_q[rd_ptr_q];

  // Word taken directly by the consumer is never stored
  assign push = valid_i & ~full & ~(empty & ready_i);
  assign pop  = ready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Push and pop together leave the fill level alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      store_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* source/stream_to_mem.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Adapter from valid/ready request and response streams to a memory port
// The memory response has no ready, so outstanding requests are capped
// at the response buffer depth
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module stream_to_mem #(
  parameter int unsigned BufDepth = 1
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request stream
  input  mem_share_pkg::mem_req_t   req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  // Response stream
  output mem_share_pkg::mem_resp_t  resp_o,
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  // Memory side, request with handshake
  output mem_share_pkg::mem_req_t   mem_req_o,
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  // Memory side, response without ready
  input  mem_share_pkg::mem_resp_t  mem_resp_i,
  input  logic                      mem_resp_valid_i
);

  // One spare bit so a wrap past zero or past the limit stays visible
  localparam int unsigned CntW = $clog2(BufDepth + 1) + 1;

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            req_take;
  logic            resp_take;
  logic            req_ok;
  // Room in the response buffer
  logic            buf_ready;

  assign req_take  = req_valid_i & req_ready_o;
  assign resp_take = resp_valid_o & resp_ready_i;

  // Outstanding requests, issued but not yet delivered
  always_comb begin
    cnt_d = cnt_q;
    if (req_take) begin
      cnt_d = cnt_d + 1'b1;
    end
    if (resp_take) begin
      cnt_d = cnt_d - 1'b1;
    end
  end

  // Below the limit, or a response leaves in this cycle
  assign req_ok = (cnt_q < CntW'(BufDepth)) | resp_take;

  // Request handshakes
  assign mem_req_valid_o = req_valid_i & req_ok;
  assign req_ready_o     = mem_req_ready_i & req_ok;

  // Payload passes unchanged
  assign mem_req_o = req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Responses wait here under back-pressure
  resp_fifo #(
    .Depth   (BufDepth)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (mem_resp_i),
    .valid_i (mem_resp_valid_i),
    .ready_o (buf_ready),
    .data_o  (resp_o),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i)
  );

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter of two adapters onto one memory port
// Returns each memory response to the port that issued the request
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Port 0
  input  mem_share_pkg::mem_req_t   req_0_i,
  input  logic                      req_valid_0_i,
  output logic                      req_ready_0_o,
  output mem_share_pkg::mem_resp_t  resp_0_o,
  output logic                      resp_valid_0_o,
  // Port 1
  input  mem_share_pkg::mem_req_t   req_1_i,
  input  logic                      req_valid_1_i,
  output logic                      req_ready_1_o,
  output mem_share_pkg::mem_resp_t  resp_1_o,
  output logic                      resp_valid_1_o,
  // Memory
  output mem_share_pkg::mem_req_t   mem_req_o,
  output logic                      mem_valid_o,
  input  mem_share_pkg::mem_resp_t  mem_resp_i,
  input  logic                      mem_resp_valid_i
);
  import mem_share_pkg::*;

  // Last granted port
  // With a latency of one cycle this is also the owner of the response in flight
  port_id_t grant_q;
  port_id_t grant_sel;
  logic     gnt_0;
  logic     gnt_1;

  // On a tie the port not granted last time wins
  assign gnt_0 = req_valid_0_i & (~req_valid_1_i | (grant_q == port_id_t'(1)));
  assign gnt_1 = req_valid_1_i & (~req_valid_0_i | (grant_q == port_id_t'(0)));

  assign grant_sel = port_id_t'(gnt_1);

  // Memory accepts every cycle, so ready is the grant
  assign req_ready_0_o = gnt_0;
  assign req_ready_1_o = gnt_1;

  assign mem_valid_o = gnt_0 | gnt_1;
  assign mem_req_o   = gnt_1 ? req_1_i : req_0_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Port 0 wins the first tie
      grant_q <= port_id_t'(1);
    end else if (mem_valid_o) begin
      grant_q <= grant_sel;
    end
  end

  // Data fans out to both ports
  assign resp_0_o = mem_resp_i;
  assign resp_1_o = mem_resp_i;

  // Valid goes to the owner only
  assign resp_valid_0_o = mem_resp_valid_i & (grant_q == port_id_t'(0));
  assign resp_valid_1_o = mem_resp_valid_i & (grant_q == port_id_t'(1));

endmodule

`default_nettype wire

/* source/sram_model.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous memory model
// Every strobe gets a response one cycle later
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_share_config.svh"

module sram_model (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mem_share_pkg::mem_req_t   req_i,
  input  logic                      valid_i,
  output mem_share_pkg::mem_resp_t  resp_o,
  output logic                      resp_valid_o
);

  localparam int unsigned Words = 2 ** `MS_ADDR_W;

  logic [`MS_DATA_W-1:0] mem_q [Words];

  // Response strobe, one cycle behind the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= valid_i;
    end
  end

  // Array and read data
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
        // Writes answer with the fixed acknowledge word
        resp_o.rdata <= `MS_WR_ACK;
      end else begin
        resp_o.rdata <= mem_q[req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* source/mem_share_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared memory with two stream requester ports
// Two adapters, the round-robin arbiter and the memory model
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_share_config.svh"

module mem_share_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Port 0
  input  mem_share_pkg::mem_req_t   req_0_i,
  input  logic                      req_valid_0_i,
  output logic                      req_ready_0_o,
  output mem_share_pkg::mem_resp_t  resp_0_o,
  output logic                      resp_valid_0_o,
  input  logic                      resp_ready_0_i,
  // Port 1
  input  mem_share_pkg::mem_req_t   req_1_i,
  input  logic                      req_valid_1_i,
  output logic                      req_ready_1_o,
  output mem_share_pkg::mem_resp_t  resp_1_o,
  output logic                      resp_valid_1_o,
  input  logic                      resp_ready_1_i
);
  import mem_share_pkg::*;

  // Adapter 0 to arbiter
  mem_req_t  adp0_req;
  logic      adp0_req_valid;
  logic      adp0_req_ready;
  mem_resp_t adp0_resp;
  logic      adp0_resp_valid;
  // Adapter 1 to arbiter
  mem_req_t  adp1_req;
  logic      adp1_req_valid;
  logic      adp1_req_ready;
  mem_resp_t adp1_resp;
  logic      adp1_resp_valid;
  // Arbiter to memory
  mem_req_t  sram_req;
  logic      sram_valid;
  mem_resp_t sram_resp;
  logic      sram_resp_valid;

  stream_to_mem #(
    .BufDepth         (`MS_BUF_DEPTH)
  ) u_adapter_0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (req_0_i),
    .req_valid_i      (req_valid_0_i),
    .req_ready_o      (req_ready_0_o),
    .resp_o           (resp_0_o),
    .resp_valid_o     (resp_valid_0_o),
    .resp_ready_i     (resp_ready_0_i),
    .mem_req_o        (adp0_req),
    .mem_req_valid_o  (adp0_req_valid),
    .mem_req_ready_i  (adp0_req_ready),
    .mem_resp_i       (adp0_resp),
    .mem_resp_valid_i (adp0_resp_valid)
  );

  stream_to_mem #(
    .BufDepth         (`MS_BUF_DEPTH)
  ) u_adapter_1 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (req_1_i),
    .req_valid_i      (req_valid_1_i),
    .req_ready_o      (req_ready_1_o),
    .resp_o           (resp_1_o),
    .resp_valid_o     (resp_valid_1_o),
    .resp_ready_i     (resp_ready_1_i),
    .mem_req_o        (adp1_req),
    .mem_req_valid_o  (adp1_req_valid),
    .mem_req_ready_i  (adp1_req_ready),
    .mem_resp_i       (adp1_resp),
    .mem_resp_valid_i (adp1_resp_valid)
  );

  mem_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_0_i          (adp0_req),
    .req_valid_0_i    (adp0_req_valid),
    .req_ready_0_o    (adp0_req_ready),
    .resp_0_o         (adp0_resp),
    .resp_valid_0_o   (adp0_resp_valid),
    .req_1_i          (adp1_req),
    .req_valid_1_i    (adp1_req_valid),
    .req_ready_1_o    (adp1_req_ready),
    .resp_1_o         (adp1_resp),
    .resp_valid_1_o   (adp1_resp_valid),
    .mem_req_o        (sram_req),
    .mem_valid_o      (sram_valid),
    .mem_resp_i       (sram_resp),
    .mem_resp_valid_i (sram_resp_valid)
  );

  sram_model u_sram (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (sram_req),
    .valid_i          (sram_valid),
    .resp_o           (sram_resp),
    .resp_valid_o     (sram_resp_valid)
  );

endmodule

`default_nettype wire

/* dv/mem_share_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Assertions on the request counter and response FIFO of an adapter
// Bound into every stream_to_mem instance
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_share_checker #(
  parameter int unsigned BufDepth = 1
) (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic [$clog2(BufDepth + 1):0] cnt_i,
  input logic                          req_valid_i,
  input logic                          req_ready_i,
  input logic                          resp_take_i,
  input logic                          fifo_wr_i,
  input logic                          fifo_ready_i
);

  localparam int unsigned CntW = $clog2(BufDepth + 1) + 1;

  // Number of failed assertions
  int unsigned fail_count = 0;
  // Outstanding requests counted from the stream handshakes alone
  logic [CntW-1:0] pending_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + CntW'(req_valid_i & req_ready_i) - CntW'(resp_take_i);
    end
  end

  // Memory response arrives only when the FIFO has room
  a_fifo_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) fifo_wr_i |-> fifo_ready_i
  ) else begin
    $error("response FIFO written while full");
    fail_count++;
  end

  // A wrap below zero shows up as a large value
  a_cnt_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cnt_i <= BufDepth
  ) else begin
    $error("outstanding counter out of range: %0d", cnt_i);
    fail_count++;
  end

  // Full adapter blocks requests unless a response leaves
  a_ready_low_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      (pending_q == BufDepth && !resp_take_i) |-> !req_ready_i
  ) else begin
    $error("request accepted with the response buffer full");
    fail_count++;
  end

endmodule

bind stream_to_mem mem_share_checker #(
  .BufDepth     (BufDepth)
) u_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .cnt_i        (cnt_q),
  .req_valid_i  (req_valid_i),
  .req_ready_i  (req_ready_o),
  .resp_take_i  (resp_take),
  .fifo_wr_i    (mem_resp_valid_i),
  .fifo_ready_i (buf_ready)
);

`default_nettype wire

/* dv/mem_share_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the shared memory with two stream ports
// Replays the request trace on both ports under random response back-pressure
// and checks each port's responses in order
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_share_config.svh"

module mem_share_tb;
  import mem_share_pkg::*;

  localparam int unsigned NumPorts = `MS_NUM_PORTS;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  mem_req_t  req_d [NumPorts];
  logic      req_valid [NumPorts];
  logic      req_ready [NumPorts];
  mem_resp_t resp [NumPorts];
  logic      resp_valid [NumPorts];
  logic      resp_ready [NumPorts];

  // Requests still to send and responses still to come, per port
  mem_req_t              send_q [NumPorts][$];
  logic [`MS_DATA_W-1:0] exp_q [NumPorts][$];
  // Reference count of accepted but undelivered requests
  int          outstanding [NumPorts];
  // Consecutive cycles lost to the other port
  int          miss [NumPorts];
  logic        expect_valid [NumPorts];
  logic        started;
  logic        loaded;
  logic [31:0] rnd_state;
  int          trace_len;
  int          resp_total;
  int          errors;

  always #50 clk_i = ~clk_i;

  mem_share_top u_mem_share_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_0_i        (req_d[0]),
    .req_valid_0_i  (req_valid[0]),
    .req_ready_0_o  (req_ready[0]),
    .resp_0_o       (resp[0]),
    .resp_valid_0_o (resp_valid[0]),
    .resp_ready_0_i (resp_ready[0]),
    .req_1_i        (req_d[1]),
    .req_valid_1_i  (req_valid[1]),
    .req_ready_1_o  (req_ready[1]),
    .resp_1_o       (resp[1]),
    .resp_valid_1_o (resp_valid[1]),
    .resp_ready_1_i (resp_ready[1])
  );

  // Xorshift step for the back-pressure pattern
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Failures seen by the bound assertions of both adapters
  function automatic int checker_fails();
    return u_mem_share_top.u_adapter_0.u_checker.fail_count
         + u_mem_share_top.u_adapter_1.u_checker.fail_count;
  endfunction

  task automatic report_counts();
    $display("errors: scoreboard %0d, checker %0d, responses %0d of %0d",
             errors, checker_fails(), resp_total, trace_len);
  endtask

  // Split the trace into per-port request and expected response queues
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] port;
    logic [31:0] we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_word;
    mem_req_t    req;
    fd = $fopen("dv/mem_share_trace.txt", "r");
    if (fd == 0) begin
      $display("error: the trace file could not be opened");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Comment and blank lines carry no entry
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", port, we, addr, wdata, exp_word);
        if (n == 5 && port < NumPorts) begin
          req.we    = we[0];
          req.addr  = addr[`MS_ADDR_W-1:0];
          req.wdata = wdata[`MS_DATA_W-1:0];
          send_q[port].push_back(req);
          exp_q[port].push_back(exp_word[`MS_DATA_W-1:0]);
          trace_len++;
        end else if (n == 5) begin
          $display("error: a trace line names port %0d, which does not exist", port);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Monitor, scoreboard and driver for both ports
  always @(posedge clk_i) begin : port_monitor
    logic                  acc [NumPorts];
    logic                  del [NumPorts];
    logic                  elig [NumPorts];
    logic [`MS_DATA_W-1:0] exp_word;
    int                    nxt;
    if (rst_n_i) begin
      // Eligible means valid with room in the adapter, or a response leaving now
      for (int p = 0; p < NumPorts; p++) begin
        acc[p]  = req_valid[p] & req_ready[p];
        del[p]  = resp_valid[p] & resp_ready[p];
        elig[p] = req_valid[p] & ((outstanding[p] < `MS_BUF_DEPTH) | del[p]);
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (!started) begin
          assert (!resp_valid[p]) else begin
            $display("error %0t resp_valid_%0d_o expected 0 got 1", $time, p);
            errors++;
          end
        end
        // Lone request shows up one cycle after acceptance
        if (expect_valid[p]) begin
          assert (resp_valid[p]) else begin
            $display("error %0t resp_valid_%0d_o expected 1 got 0", $time, p);
            errors++;
          end
        end
        if (del[p]) begin
          resp_total++;
          assert (exp_q[p].size() > 0) else begin
            $display("error: port %0d delivered a response that was never requested", p);
            errors++;
          end
          if (exp_q[p].size() > 0) begin
            exp_word = exp_q[p].pop_front();
            assert (resp[p].rdata == exp_word) else begin
              $display("error %0t resp_%0d_o expected %h got %h",
                       $time, p, exp_word, resp[p].rdata);
              errors++;
            end
          end
        end
        nxt = outstanding[p] + int'(acc[p]) - int'(del[p]);
        assert (nxt <= `MS_BUF_DEPTH) else begin
          $display("error %0t outstanding_%0d expected at most %0d got %0d",
                   $time, p, `MS_BUF_DEPTH, nxt);
          errors++;
        end
        outstanding[p]  = nxt;
        expect_valid[p] = acc[p] & (nxt == 1);
        // Round-robin fairness while both ports can go
        if (elig[0] & elig[1] & !acc[p]) begin
          miss[p]++;
        end else begin
          miss[p] = 0;
        end
        assert (miss[p] < 2) else begin
          $display("error: port %0d was passed over two cycles in a row", p);
          errors++;
        end
        // Next request once the current one is taken
        if (acc[p] | !req_valid[p]) begin
          if (started && send_q[p].size() > 0) begin
            req_d[p]     <= send_q[p].pop_front();
            req_valid[p] <= 1'b1;
          end else begin
            req_valid[p] <= 1'b0;
          end
        end
      end
      rnd_state = next_random(rnd_state);
      resp_ready[0] <= rnd_state[3] | rnd_state[7];
      resp_ready[1] <= rnd_state[12] | rnd_state[20];
    end
  end

  initial begin : main_flow
    rst_n_i = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      req_d[p]        = '0;
      req_valid[p]    = 1'b0;
      resp_ready[p]   = 1'b0;
      outstanding[p]  = 0;
      miss[p]         = 0;
      expect_valid[p] = 1'b0;
    end
    started    = 1'b0;
    loaded     = 1'b0;
    rnd_state  = 32'h1113;
    trace_len  = 0;
    resp_total = 0;
    errors     = 0;
    load_trace();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle so the response valids can be seen staying low
    repeat (3) @(posedge clk_i);
    started <= 1'b1;
    wait (resp_total == trace_len);
    // A few spare cycles catch any duplicate response
    repeat (4) @(posedge clk_i);
    assert (resp_total == trace_len) else begin
      $display("error %0t resp_total expected %0d got %0d", $time, trace_len, resp_total);
      errors++;
    end
    for (int p = 0; p < NumPorts; p++) begin
      assert (exp_q[p].size() == 0 && send_q[p].size() == 0) else begin
        $display("error: port %0d ended with requests or responses left over", p);
        errors++;
      end
    end
    report_counts();
    if (errors == 0 && checker_fails() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Bound on run time from the trace length
  initial begin : watchdog
    wait (loaded);
    repeat (20 * (trace_len + 1)) @(posedge clk_i);
    $display("timeout: not all %0d responses arrived in time", trace_len);
    report_counts();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/mem_share_pkg.sv
source/resp_fifo.sv
source/stream_to_mem.sv
source/mem_arbiter.sv
source/sram_model.sv
source/mem_share_top.sv
dv/mem_share_checker.sv
dv/mem_share_tb.sv

/* dv/mem_share_trace.txt */
# port we addr wdata expected, all hex
# port 0 uses addresses 00-1f, port 1 uses 20-3f
0 1 03 1234 a5a5
0 0 03 0000 1234
1 1 25 beef a5a5
1 0 25 0000 beef
0 1 04 0a0a a5a5
1 1 26 5555 a5a5
0 1 05 c3c3 a5a5
1 0 26 0000 5555
0 0 04 0000 0a0a
0 0 05 0000 c3c3
1 1 25 7777 a5a5
1 0 25 0000 7777
0 1 03 0f0f a5a5
0 0 03 0000 0f0f
